// File: rtl/xbar_pkg.sv
package xbar_pkg;

    localparam int MASTER_NUM       = 2;
    localparam int SLAVE_NUM        = 2;
    localparam int MASTER_IDX_WIDTH = 1;
    localparam int SLAVE_IDX_WIDTH  = 1;

    localparam int ADDR_WIDTH       = 32;
    localparam int DATA_WIDTH       = 32;
    localparam int STRB_WIDTH       = DATA_WIDTH / 8;
    localparam int LEN_WIDTH        = 8;
    localparam int RESP_WIDTH       = 2;

    // master side id, widened by the master index on the slave side
    localparam int ID_WIDTH         = 4;
    localparam int EXT_ID_WIDTH     = MASTER_IDX_WIDTH + ID_WIDTH;

    // lowest address bit of the slave select field
    localparam int SLAVE_SEL_LSB    = 28;

    // entries in every W route queue and W order queue
    localparam int ROUTE_DEPTH      = 4;

    // slave side id, seen either as one word or as its two fields
    typedef union packed {
        logic [EXT_ID_WIDTH-1:0] raw;
        struct packed {
            logic [MASTER_IDX_WIDTH-1:0] master;
            logic [ID_WIDTH-1:0]         id;
        } f;
    } ext_id_u;

endpackage

// File: rtl/route_fifo.sv
`timescale 1ns/100ps

module route_fifo #(
    parameter int WIDTH = 1,
    parameter int DEPTH = 4
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             push,
    input  logic [WIDTH-1:0] push_data,
    input  logic             pop,
    output logic [WIDTH-1:0] head,
    output logic             empty,
    output logic             full
);

    localparam int PTR_WIDTH = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_WIDTH = $clog2(DEPTH + 1);

    logic [WIDTH-1:0]     mem [DEPTH];
    logic [PTR_WIDTH-1:0] wr_ptr;
    logic [PTR_WIDTH-1:0] rd_ptr;
    logic [CNT_WIDTH-1:0] count;

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_WIDTH'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_WIDTH'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // simultaneous push and pop leaves the count alone
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

    assign head  = mem[rd_ptr];
    assign empty = (count == '0);
    assign full  = (count == CNT_WIDTH'(DEPTH));

    a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n) !(push && full));
    a_no_underflow: assert property (@(posedge clk) disable iff (!rst_n) !(pop && empty));

endmodule

// File: rtl/rr_arbiter.sv
`timescale 1ns/100ps

module rr_arbiter #(
    parameter int REQ_NUM = 2
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic [REQ_NUM-1:0] req,
    input  logic               done,
    output logic [REQ_NUM-1:0] grant
);

    localparam int IDX_WIDTH = (REQ_NUM > 1) ? $clog2(REQ_NUM) : 1;

    logic                 held;
    logic [REQ_NUM-1:0]   held_grant;
    logic [REQ_NUM-1:0]   pick;
    logic [IDX_WIDTH-1:0] last_idx;
    logic [IDX_WIDTH-1:0] win_idx;

    // first requester after the last winner, wrapping around
    always_comb begin
        int idx;
        pick = '0;
        for (int k = REQ_NUM; k >= 1; k--) begin
            idx = (int'(last_idx) + k) % REQ_NUM;
            if (req[idx]) begin
                pick = '0;
                pick[idx] = 1'b1;
            end
        end
    end

    assign grant = held ? held_grant : pick;

    always_comb begin
        win_idx = last_idx;
        for (int k = 0; k < REQ_NUM; k++) begin
            if (grant[k]) begin
                win_idx = IDX_WIDTH'(k);
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            held       <= 1'b0;
            held_grant <= '0;
            last_idx   <= IDX_WIDTH'(REQ_NUM - 1);
        end else if (done) begin
            held     <= 1'b0;
            last_idx <= win_idx;
        end else if (|grant) begin
            // keep the winner until its handshake
            held       <= 1'b1;
            held_grant <= grant;
        end
    end

    a_grant_onehot: assert property (@(posedge clk) disable iff (!rst_n) $onehot0(grant));

endmodule

// File: rtl/master_port.sv
`timescale 1ns/100ps

module master_port (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  logic                                 awvalid,
    input  logic [xbar_pkg::ADDR_WIDTH-1:0]      awaddr,
    input  logic                                 awready,
    input  logic                                 wvalid,
    input  logic                                 wready,
    input  logic                                 wlast,
    output logic [xbar_pkg::SLAVE_NUM-1:0]       aw_req,
    output logic [xbar_pkg::SLAVE_IDX_WIDTH-1:0] w_head,
    output logic                                 w_pending
);

    import xbar_pkg::*;

    logic [SLAVE_IDX_WIDTH-1:0] aw_slave;
    logic                       route_push;
    logic                       route_pop;
    logic                       route_empty;
    logic                       route_full;

    assign aw_slave = awaddr[SLAVE_SEL_LSB +: SLAVE_IDX_WIDTH];

    // no request to any slave while the route queue has no room
    for (genvar s = 0; s < SLAVE_NUM; s++) begin : g_req
        assign aw_req[s] = awvalid && !route_full && (aw_slave == SLAVE_IDX_WIDTH'(s));
    end

    assign route_push = awvalid && awready;
    assign route_pop  = wvalid && wready && wlast;

    route_fifo #(
        .WIDTH (SLAVE_IDX_WIDTH),
        .DEPTH (ROUTE_DEPTH)
    ) i_route_fifo (
        .clk       (clk),
        .rst_n     (rst_n),
        .push      (route_push),
        .push_data (aw_slave),
        .pop       (route_pop),
        .head      (w_head),
        .empty     (route_empty),
        .full      (route_full)
    );

    assign w_pending = !route_empty;

endmodule

// File: rtl/slave_port.sv
`timescale 1ns/100ps

module slave_port #(
    parameter int SLAVE_INDEX = 0
) (
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  logic [xbar_pkg::SLAVE_NUM-1:0]        aw_req [xbar_pkg::MASTER_NUM],
    input  logic [xbar_pkg::ADDR_WIDTH-1:0]       awaddr [xbar_pkg::MASTER_NUM],
    input  logic [xbar_pkg::ID_WIDTH-1:0]         awid [xbar_pkg::MASTER_NUM],
    input  logic [xbar_pkg::LEN_WIDTH-1:0]        awlen [xbar_pkg::MASTER_NUM],
    input  logic [xbar_pkg::SLAVE_IDX_WIDTH-1:0]  w_head [xbar_pkg::MASTER_NUM],
    input  logic [xbar_pkg::MASTER_NUM-1:0]       w_pending,
    input  logic [xbar_pkg::MASTER_NUM-1:0]       wvalid,
    input  logic [xbar_pkg::DATA_WIDTH-1:0]       wdata [xbar_pkg::MASTER_NUM],
    input  logic [xbar_pkg::STRB_WIDTH-1:0]       wstrb [xbar_pkg::MASTER_NUM],
    input  logic [xbar_pkg::MASTER_NUM-1:0]       wlast,
    input  logic                                  awready,
    input  logic                                  wready,
    output logic [xbar_pkg::MASTER_NUM-1:0]       aw_grant,
    output logic [xbar_pkg::MASTER_NUM-1:0]       w_ready_to_master,
    output logic                                  s_awvalid,
    output logic [xbar_pkg::ADDR_WIDTH-1:0]       s_awaddr,
    output logic [xbar_pkg::EXT_ID_WIDTH-1:0]     s_awid,
    output logic [xbar_pkg::LEN_WIDTH-1:0]        s_awlen,
    output logic                                  s_wvalid,
    output logic [xbar_pkg::DATA_WIDTH-1:0]       s_wdata,
    output logic [xbar_pkg::STRB_WIDTH-1:0]       s_wstrb,
    output logic                                  s_wlast
);

    import xbar_pkg::*;

    logic [MASTER_NUM-1:0]       aw_open;
    logic [MASTER_NUM-1:0]       grant;
    logic [MASTER_IDX_WIDTH-1:0] aw_sel;
    logic [MASTER_IDX_WIDTH-1:0] w_sel;
    logic                        order_empty;
    logic                        order_full;
    logic                        w_open;
    ext_id_u                     ext_id;

    // requests masked while the order queue is full
    always_comb begin
        for (int m = 0; m < MASTER_NUM; m++) begin
            aw_open[m] = aw_req[m][SLAVE_INDEX] && !order_full;
        end
    end

    rr_arbiter #(
        .REQ_NUM (MASTER_NUM)
    ) i_aw_arbiter (
        .clk   (clk),
        .rst_n (rst_n),
        .req   (aw_open),
        .done  (s_awvalid && awready),
        .grant (grant)
    );

    always_comb begin
        aw_sel = '0;
        for (int m = 0; m < MASTER_NUM; m++) begin
            if (grant[m]) begin
                aw_sel = MASTER_IDX_WIDTH'(m);
            end
        end
    end

    // master index goes on top of the id
    always_comb begin
        ext_id.f.master = aw_sel;
        ext_id.f.id     = awid[aw_sel];
    end

    assign s_awvalid = |(grant & aw_open);
    assign s_awaddr  = awaddr[aw_sel];
    assign s_awid    = ext_id.raw;
    assign s_awlen   = awlen[aw_sel];
    // per master awready contribution
    assign aw_grant  = (grant & aw_open) & {MASTER_NUM{awready}};

    route_fifo #(
        .WIDTH (MASTER_IDX_WIDTH),
        .DEPTH (ROUTE_DEPTH)
    ) i_order_fifo (
        .clk       (clk),
        .rst_n     (rst_n),
        .push      (s_awvalid && awready),
        .push_data (aw_sel),
        .pop       (s_wvalid && wready && s_wlast),
        .head      (w_sel),
        .empty     (order_empty),
        .full      (order_full)
    );

    // W follows AW order, and the master must be on a burst for this slave
    assign w_open = !order_empty && w_pending[w_sel]
                 && (w_head[w_sel] == SLAVE_IDX_WIDTH'(SLAVE_INDEX));

    assign s_wvalid = w_open && wvalid[w_sel];
    assign s_wdata  = wdata[w_sel];
    assign s_wstrb  = wstrb[w_sel];
    assign s_wlast  = wlast[w_sel];

    always_comb begin
        for (int m = 0; m < MASTER_NUM; m++) begin
            w_ready_to_master[m] = w_open && (w_sel == MASTER_IDX_WIDTH'(m)) && wready;
        end
    end

    a_aw_stable: assert property (@(posedge clk) disable iff (!rst_n)
        s_awvalid && !awready |=> s_awvalid && $stable(s_awaddr)
                                  && $stable(s_awid) && $stable(s_awlen));

endmodule

// File: rtl/bresp_router.sv
`timescale 1ns/100ps

module bresp_router #(
    parameter int MASTER_INDEX = 0
) (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic [xbar_pkg::SLAVE_NUM-1:0]     s_bvalid,
    input  logic [xbar_pkg::EXT_ID_WIDTH-1:0]  s_bid [xbar_pkg::SLAVE_NUM],
    input  logic [xbar_pkg::RESP_WIDTH-1:0]    s_bresp [xbar_pkg::SLAVE_NUM],
    input  logic                               bready,
    output logic                               bvalid,
    output logic [xbar_pkg::ID_WIDTH-1:0]      bid,
    output logic [xbar_pkg::RESP_WIDTH-1:0]    bresp,
    output logic [xbar_pkg::SLAVE_NUM-1:0]     s_bready_from_master
);

    import xbar_pkg::*;

    ext_id_u                    bid_ext [SLAVE_NUM];
    logic [SLAVE_NUM-1:0]       req;
    logic [SLAVE_NUM-1:0]       grant;
    logic [SLAVE_IDX_WIDTH-1:0] b_sel;

    // a slave asks only for responses owned by this master
    always_comb begin
        for (int s = 0; s < SLAVE_NUM; s++) begin
            bid_ext[s].raw = s_bid[s];
            req[s] = s_bvalid[s]
                  && (bid_ext[s].f.master == MASTER_IDX_WIDTH'(MASTER_INDEX));
        end
    end

    rr_arbiter #(
        .REQ_NUM (SLAVE_NUM)
    ) i_b_arbiter (
        .clk   (clk),
        .rst_n (rst_n),
        .req   (req),
        .done  (bvalid && bready),
        .grant (grant)
    );

    always_comb begin
        b_sel = '0;
        for (int s = 0; s < SLAVE_NUM; s++) begin
            if (grant[s]) begin
                b_sel = SLAVE_IDX_WIDTH'(s);
            end
        end
    end

    assign bvalid = |(grant & req);
    // master index dropped on the way back
    assign bid    = bid_ext[b_sel].f.id;
    assign bresp  = s_bresp[b_sel];

    assign s_bready_from_master = (grant & req) & {SLAVE_NUM{bready}};

    a_b_stable: assert property (@(posedge clk) disable iff (!rst_n)
        bvalid && !bready |=> bvalid && $stable(bid) && $stable(bresp));

endmodule

// File: rtl/axi_write_xbar.sv
`timescale 1ns/100ps

module axi_write_xbar (
    input  logic                                clk,
    input  logic                                rst_n,
    // master side
    input  logic [xbar_pkg::MASTER_NUM-1:0]     m_awvalid,
    input  logic [xbar_pkg::ADDR_WIDTH-1:0]     m_awaddr [xbar_pkg::MASTER_NUM],
    input  logic [xbar_pkg::ID_WIDTH-1:0]       m_awid [xbar_pkg::MASTER_NUM],
    input  logic [xbar_pkg::LEN_WIDTH-1:0]      m_awlen [xbar_pkg::MASTER_NUM],
    output logic [xbar_pkg::MASTER_NUM-1:0]     m_awready,
    input  logic [xbar_pkg::MASTER_NUM-1:0]     m_wvalid,
    input  logic [xbar_pkg::DATA_WIDTH-1:0]     m_wdata [xbar_pkg::MASTER_NUM],
    input  logic [xbar_pkg::STRB_WIDTH-1:0]     m_wstrb [xbar_pkg::MASTER_NUM],
    input  logic [xbar_pkg::MASTER_NUM-1:0]     m_wlast,
    output logic [xbar_pkg::MASTER_NUM-1:0]     m_wready,
    output logic [xbar_pkg::MASTER_NUM-1:0]     m_bvalid,
    output logic [xbar_pkg::ID_WIDTH-1:0]       m_bid [xbar_pkg::MASTER_NUM],
    output logic [xbar_pkg::RESP_WIDTH-1:0]     m_bresp [xbar_pkg::MASTER_NUM],
    input  logic [xbar_pkg::MASTER_NUM-1:0]     m_bready,
    // slave side
    output logic [xbar_pkg::SLAVE_NUM-1:0]      s_awvalid,
    output logic [xbar_pkg::ADDR_WIDTH-1:0]     s_awaddr [xbar_pkg::SLAVE_NUM],
    output logic [xbar_pkg::EXT_ID_WIDTH-1:0]   s_awid [xbar_pkg::SLAVE_NUM],
    output logic [xbar_pkg::LEN_WIDTH-1:0]      s_awlen [xbar_pkg::SLAVE_NUM],
    input  logic [xbar_pkg::SLAVE_NUM-1:0]      s_awready,
    output logic [xbar_pkg::SLAVE_NUM-1:0]      s_wvalid,
    output logic [xbar_pkg::DATA_WIDTH-1:0]     s_wdata [xbar_pkg::SLAVE_NUM],
    output logic [xbar_pkg::STRB_WIDTH-1:0]     s_wstrb [xbar_pkg::SLAVE_NUM],
    output logic [xbar_pkg::SLAVE_NUM-1:0]      s_wlast,
    input  logic [xbar_pkg::SLAVE_NUM-1:0]      s_wready,
    input  logic [xbar_pkg::SLAVE_NUM-1:0]      s_bvalid,
    input  logic [xbar_pkg::EXT_ID_WIDTH-1:0]   s_bid [xbar_pkg::SLAVE_NUM],
    input  logic [xbar_pkg::RESP_WIDTH-1:0]     s_bresp [xbar_pkg::SLAVE_NUM],
    output logic [xbar_pkg::SLAVE_NUM-1:0]      s_bready
);

    import xbar_pkg::*;

    logic [SLAVE_NUM-1:0]       aw_req [MASTER_NUM];
    logic [SLAVE_IDX_WIDTH-1:0] w_head [MASTER_NUM];
    logic [MASTER_NUM-1:0]      w_pending;
    logic [MASTER_NUM-1:0]      aw_grant [SLAVE_NUM];
    logic [MASTER_NUM-1:0]      w_ready_to_master [SLAVE_NUM];
    logic [SLAVE_NUM-1:0]       s_bready_from_master [MASTER_NUM];

    for (genvar m = 0; m < MASTER_NUM; m++) begin : g_master
        master_port i_master_port (
            .clk       (clk),
            .rst_n     (rst_n),
            .awvalid   (m_awvalid[m]),
            .awaddr    (m_awaddr[m]),
            .awready   (m_awready[m]),
            .wvalid    (m_wvalid[m]),
            .wready    (m_wready[m]),
            .wlast     (m_wlast[m]),
            .aw_req    (aw_req[m]),
            .w_head    (w_head[m]),
            .w_pending (w_pending[m])
        );

        bresp_router #(
            .MASTER_INDEX (m)
        ) i_bresp_router (
            .clk                  (clk),
            .rst_n                (rst_n),
            .s_bvalid             (s_bvalid),
            .s_bid                (s_bid),
            .s_bresp              (s_bresp),
            .bready               (m_bready[m]),
            .bvalid               (m_bvalid[m]),
            .bid                  (m_bid[m]),
            .bresp                (m_bresp[m]),
            .s_bready_from_master (s_bready_from_master[m])
        );
    end

    for (genvar s = 0; s < SLAVE_NUM; s++) begin : g_slave
        slave_port #(
            .SLAVE_INDEX (s)
        ) i_slave_port (
            .clk               (clk),
            .rst_n             (rst_n),
            .aw_req            (aw_req),
            .awaddr            (m_awaddr),
            .awid              (m_awid),
            .awlen             (m_awlen),
            .w_head            (w_head),
            .w_pending         (w_pending),
            .wvalid            (m_wvalid),
            .wdata             (m_wdata),
            .wstrb             (m_wstrb),
            .wlast             (m_wlast),
            .awready           (s_awready[s]),
            .wready            (s_wready[s]),
            .aw_grant          (aw_grant[s]),
            .w_ready_to_master (w_ready_to_master[s]),
            .s_awvalid         (s_awvalid[s]),
            .s_awaddr          (s_awaddr[s]),
            .s_awid            (s_awid[s]),
            .s_awlen           (s_awlen[s]),
            .s_wvalid          (s_wvalid[s]),
            .s_wdata           (s_wdata[s]),
            .s_wstrb           (s_wstrb[s]),
            .s_wlast           (s_wlast[s])
        );
    end

    // at most one port drives each ready high, so OR merges them
    always_comb begin
        m_awready = '0;
        m_wready  = '0;
        s_bready  = '0;
        for (int s = 0; s < SLAVE_NUM; s++) begin
            m_awready = m_awready | aw_grant[s];
            m_wready  = m_wready | w_ready_to_master[s];
        end
        for (int m = 0; m < MASTER_NUM; m++) begin
            s_bready = s_bready | s_bready_from_master[m];
        end
    end

endmodule

// File: tests/tb_slave_model.sv
`timescale 1ns/100ps

module tb_slave_model #(
    parameter int SLAVE_INDEX = 0
) (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic [1:0]                          rnd,
    input  logic                                awvalid,
    input  logic [xbar_pkg::EXT_ID_WIDTH-1:0]   awid,
    output logic                                awready,
    input  logic                                wvalid,
    input  logic                                wlast,
    output logic                                wready,
    output logic                                bvalid,
    output logic [xbar_pkg::EXT_ID_WIDTH-1:0]   bid,
    output logic [xbar_pkg::RESP_WIDTH-1:0]     bresp,
    input  logic                                bready
);

    import xbar_pkg::*;

    logic [EXT_ID_WIDTH-1:0] aw_q [$];
    logic [EXT_ID_WIDTH-1:0] b_q [$];

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            awready <= 1'b0;
            wready  <= 1'b0;
            bvalid  <= 1'b0;
            bid     <= '0;
            bresp   <= '0;
        end else begin
            awready <= rnd[0];
            wready  <= rnd[1];
            if (awvalid && awready) begin
                aw_q.push_back(awid);
            end
            // one response per finished burst, in burst order
            if (wvalid && wready && wlast && aw_q.size() > 0) begin
                b_q.push_back(aw_q.pop_front());
            end
            if (bvalid && bready) begin
                bvalid <= 1'b0;
            end else if (!bvalid && b_q.size() > 0) begin
                bvalid <= 1'b1;
                bid    <= b_q.pop_front();
                bresp  <= {1'b0, SLAVE_IDX_WIDTH'(SLAVE_INDEX)};
            end
        end
    end

endmodule

// File: tests/tb_top.sv
`timescale 1ns/100ps

module tb_top;

    import xbar_pkg::*;

    localparam int BURST_NUM   = 40;
    localparam int MAX_BEATS   = 4;
    // generous margin per beat for random back-pressure
    localparam int CYCLE_LIMIT = BURST_NUM * (MAX_BEATS + 1) * 100;

    logic                        clk;
    logic                        rst_n;
    logic [MASTER_NUM-1:0]       m_awvalid;
    logic [ADDR_WIDTH-1:0]       m_awaddr [MASTER_NUM];
    logic [ID_WIDTH-1:0]         m_awid [MASTER_NUM];
    logic [LEN_WIDTH-1:0]        m_awlen [MASTER_NUM];
    logic [MASTER_NUM-1:0]       m_awready;
    logic [MASTER_NUM-1:0]       m_wvalid;
    logic [DATA_WIDTH-1:0]       m_wdata [MASTER_NUM];
    logic [STRB_WIDTH-1:0]       m_wstrb [MASTER_NUM];
    logic [MASTER_NUM-1:0]       m_wlast;
    logic [MASTER_NUM-1:0]       m_wready;
    logic [MASTER_NUM-1:0]       m_bvalid;
    logic [ID_WIDTH-1:0]         m_bid [MASTER_NUM];
    logic [RESP_WIDTH-1:0]       m_bresp [MASTER_NUM];
    logic [MASTER_NUM-1:0]       m_bready;
    logic [SLAVE_NUM-1:0]        s_awvalid;
    logic [ADDR_WIDTH-1:0]       s_awaddr [SLAVE_NUM];
    logic [EXT_ID_WIDTH-1:0]     s_awid [SLAVE_NUM];
    logic [LEN_WIDTH-1:0]        s_awlen [SLAVE_NUM];
    logic [SLAVE_NUM-1:0]        s_awready;
    logic [SLAVE_NUM-1:0]        s_wvalid;
    logic [DATA_WIDTH-1:0]       s_wdata [SLAVE_NUM];
    logic [STRB_WIDTH-1:0]       s_wstrb [SLAVE_NUM];
    logic [SLAVE_NUM-1:0]        s_wlast;
    logic [SLAVE_NUM-1:0]        s_wready;
    logic [SLAVE_NUM-1:0]        s_bvalid;
    logic [EXT_ID_WIDTH-1:0]     s_bid [SLAVE_NUM];
    logic [RESP_WIDTH-1:0]       s_bresp [SLAVE_NUM];
    logic [SLAVE_NUM-1:0]        s_bready;
    logic [1:0]                  slv_rand [SLAVE_NUM];

    logic [31:0] lfsr;
    int          errors;
    int          cycles;
    logic        started;
    int          issued [MASTER_NUM];
    int          beat [MASTER_NUM];
    int          len [MASTER_NUM];
    int          tgt [MASTER_NUM];
    int          aw_cnt [MASTER_NUM];
    int          b_cnt [MASTER_NUM];
    int          w_beat [SLAVE_NUM];
    // {slave, id} of bursts still waiting for B, per master
    logic [7:0]  open_q [MASTER_NUM][$];
    // {master, len} of AWs accepted at each slave
    logic [15:0] order_q [SLAVE_NUM][$];

    axi_write_xbar i_dut (.*);

    for (genvar s = 0; s < SLAVE_NUM; s++) begin : g_slave
        tb_slave_model #(
            .SLAVE_INDEX (s)
        ) i_slave (
            .clk     (clk),
            .rst_n   (rst_n),
            .rnd     (slv_rand[s]),
            .awvalid (s_awvalid[s]),
            .awid    (s_awid[s]),
            .awready (s_awready[s]),
            .wvalid  (s_wvalid[s]),
            .wlast   (s_wlast[s]),
            .wready  (s_wready[s]),
            .bvalid  (s_bvalid[s]),
            .bid     (s_bid[s]),
            .bresp   (s_bresp[s]),
            .bready  (s_bready[s])
        );

        a_aw_route: assert property (@(posedge clk) disable iff (!rst_n)
            s_awvalid[s] && s_awready[s] |-> aw_matches(s))
        else begin
            errors++;
            $display("%0t: AW at slave %0d has no matching master AW", $time, s);
        end

        a_aw_hold: assert property (@(posedge clk) disable iff (!rst_n)
            s_awvalid[s] && !s_awready[s] |=> $stable(s_awaddr[s])
                && $stable(s_awid[s]) && $stable(s_awlen[s]))
        else begin
            errors++;
            $display("%0t: AW payload at slave %0d changed while stalled", $time, s);
        end
    end

    a_idle_after_reset: assert property (@(posedge clk) disable iff (!rst_n)
        !started |-> s_awvalid == '0 && s_wvalid == '0 && m_bvalid == '0)
    else begin
        errors++;
        $display("%0t: valid output raised before any stimulus", $time);
    end

    function automatic logic [31:0] galois_next(logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic logic [31:0] take_bits(int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[30:0], lfsr[0]};
            lfsr = galois_next(lfsr);
        end
        return r;
    endfunction

    function automatic logic [31:0] beat_data(int m, int s, int b);
        return (32'(m) << 16) | (32'(s) << 8) | 32'(b);
    endfunction

    // strobe differs per master and beat
    function automatic logic [STRB_WIDTH-1:0] beat_strb(int m, int b);
        return STRB_WIDTH'(m * 4 + b + 1);
    endfunction

    function automatic bit aw_matches(int s);
        int f;
        f = int'(s_awid[s][EXT_ID_WIDTH-1]);
        return s_awaddr[s][SLAVE_SEL_LSB] == 1'(s) && m_awvalid[f] && m_awready[f]
            && m_awaddr[f] == s_awaddr[s] && m_awid[f] == s_awid[s][ID_WIDTH-1:0]
            && m_awlen[f] == s_awlen[s];
    endfunction

    task automatic report_mismatch(string name, logic [31:0] exp, logic [31:0] got);
        errors++;
        $display("ERR %0t %s exp %h got %h", $time, name, exp, got);
    endtask

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // master stimulus and slave ready randomness
    always @(posedge clk) begin
        logic aw_busy;
        logic w_busy;
        if (rst_n) begin
            for (int m = 0; m < MASTER_NUM; m++) begin
                aw_busy = m_awvalid[m] && !m_awready[m];
                w_busy  = m_wvalid[m] && !(m_wready[m] && m_wlast[m]);
                if (m_awvalid[m] && m_awready[m]) begin
                    m_awvalid[m] <= 1'b0;
                end
                if (m_wvalid[m] && m_wready[m] && !m_wlast[m]) begin
                    beat[m]++;
                    m_wdata[m] <= beat_data(m, tgt[m], beat[m]);
                    m_wstrb[m] <= beat_strb(m, beat[m]);
                    m_wlast[m] <= (beat[m] == len[m]);
                end
                if (!aw_busy && !w_busy && issued[m] < BURST_NUM) begin
                    tgt[m]  = int'(take_bits(1));
                    len[m]  = int'(take_bits(2));
                    beat[m] = 0;
                    issued[m]++;
                    started     <= 1'b1;
                    m_awvalid[m] <= 1'b1;
                    m_awaddr[m] <= (32'(tgt[m]) << SLAVE_SEL_LSB) | take_bits(16);
                    m_awid[m]   <= ID_WIDTH'(take_bits(ID_WIDTH));
                    m_awlen[m]  <= LEN_WIDTH'(len[m]);
                    m_wvalid[m] <= 1'b1;
                    m_wdata[m]  <= beat_data(m, tgt[m], 0);
                    m_wstrb[m]  <= beat_strb(m, 0);
                    m_wlast[m]  <= (len[m] == 0);
                end else if (!w_busy) begin
                    m_wvalid[m] <= 1'b0;
                end
                m_bready[m] <= 1'(take_bits(1));
            end
            for (int s = 0; s < SLAVE_NUM; s++) begin
                slv_rand[s] <= 2'(take_bits(2));
            end
        end
    end

    // reference queues and per-transfer checks
    always @(posedge clk) begin
        logic [15:0] head;
        int          hit;
        if (rst_n) begin
            for (int s = 0; s < SLAVE_NUM; s++) begin
                if (s_wvalid[s] && s_wready[s]) begin
                    assert (order_q[s].size() > 0)
                    else begin
                        errors++;
                        $display("%0t: W beat at slave %0d without an accepted AW", $time, s);
                    end
                    if (order_q[s].size() > 0) begin
                        head = order_q[s][0];
                        assert (s_wdata[s] == beat_data(head[15:8], s, w_beat[s]))
                        else report_mismatch("s_wdata", beat_data(head[15:8], s, w_beat[s]),
                                             s_wdata[s]);
                        assert (s_wstrb[s] == beat_strb(head[15:8], w_beat[s]))
                        else report_mismatch("s_wstrb", 32'(beat_strb(head[15:8], w_beat[s])),
                                             32'(s_wstrb[s]));
                        assert (s_wlast[s] == (w_beat[s] == int'(head[7:0])))
                        else report_mismatch("s_wlast", 32'(w_beat[s] == int'(head[7:0])),
                                             32'(s_wlast[s]));
                        w_beat[s]++;
                        if (s_wlast[s]) begin
                            void'(order_q[s].pop_front());
                            w_beat[s] = 0;
                        end
                    end
                end
                if (s_awvalid[s] && s_awready[s]) begin
                    order_q[s].push_back({8'(s_awid[s][EXT_ID_WIDTH-1]), s_awlen[s]});
                end
            end
            for (int m = 0; m < MASTER_NUM; m++) begin
                if (m_awvalid[m] && m_awready[m]) begin
                    aw_cnt[m]++;
                    open_q[m].push_back({3'(m_awaddr[m][SLAVE_SEL_LSB]), 1'b0, m_awid[m]});
                end
                if (m_bvalid[m] && m_bready[m]) begin
                    b_cnt[m]++;
                    hit = -1;
                    for (int i = open_q[m].size() - 1; i >= 0; i--) begin
                        if (open_q[m][i] == {3'(m_bresp[m]), 1'b0, m_bid[m]}) begin
                            hit = i;
                        end
                    end
                    assert (hit >= 0)
                    else begin
                        errors++;
                        $display("%0t: B at master %0d with id %h resp %h matches no open burst",
                                 $time, m, m_bid[m], m_bresp[m]);
                    end
                    if (hit >= 0) begin
                        open_q[m].delete(hit);
                    end
                end
            end
        end
    end

    initial begin
        lfsr      = 32'h597a_cca2;
        errors    = 0;
        cycles    = 0;
        started   = 1'b0;
        rst_n     = 1'b0;
        m_awvalid = '0;
        m_wvalid  = '0;
        m_wlast   = '0;
        m_bready  = '0;
        for (int m = 0; m < MASTER_NUM; m++) begin
            m_awaddr[m] = '0;
            m_awid[m]   = '0;
            m_awlen[m]  = '0;
            m_wdata[m]  = '0;
            m_wstrb[m]  = '1;
            issued[m]   = 0;
            aw_cnt[m]   = 0;
            b_cnt[m]    = 0;
        end
        for (int s = 0; s < SLAVE_NUM; s++) begin
            slv_rand[s] = '0;
            w_beat[s]   = 0;
        end
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
        while (!(b_cnt[0] == BURST_NUM && b_cnt[1] == BURST_NUM) && cycles < CYCLE_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        if (cycles >= CYCLE_LIMIT) begin
            errors++;
            for (int m = 0; m < MASTER_NUM; m++) begin
                if (b_cnt[m] < BURST_NUM) begin
                    $display("timeout: master %0d still has bursts without a response", m);
                end
            end
        end
        repeat (5) @(posedge clk);
        for (int m = 0; m < MASTER_NUM; m++) begin
            assert (aw_cnt[m] == BURST_NUM)
            else report_mismatch("aw_count", BURST_NUM, aw_cnt[m]);
            assert (b_cnt[m] == aw_cnt[m])
            else report_mismatch("b_count", aw_cnt[m], b_cnt[m]);
        end
        $display("aw %0d/%0d  b %0d/%0d  errors %0d", aw_cnt[0], aw_cnt[1], b_cnt[0],
                 b_cnt[1], errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// File: tb.f
rtl/xbar_pkg.sv
rtl/route_fifo.sv
rtl/rr_arbiter.sv
rtl/master_port.sv
rtl/slave_port.sv
rtl/bresp_router.sv
rtl/axi_write_xbar.sv
tests/tb_slave_model.sv
tests/tb_top.sv

// File: run.sh
#!/bin/sh
# build and run the crossbar testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module tb_top -Mdir obj_dir -o vtb_top \
    -f tb.f
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/vtb_top > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "TEST FAIL" sim.log; then
    exit 1
fi
exit 0
